// ==== source/addr_map_pkg.sv ====
`default_nettype none

package addr_map_pkg;

  // Byte address carried by every request and used for both rule bounds
  typedef logic [31:0] addr_t;

  // Picks one of up to eight rule slots on the configuration port
  typedef logic [2:0] rule_sel_t;

  // Width of a port index for a given number of ports
  // A single port still gets one index bit so the vectors never collapse
  function automatic int unsigned idx_width(input int unsigned num_idx);
    int unsigned width;
    width = (num_idx > 32'd1) ? unsigned'($clog2(num_idx)) : 32'd1;
    return width;
  endfunction

endpackage

`default_nettype wire

// ==== source/router_pkg.sv ====
`default_nettype none

package router_pkg;

  // Payload word that travels with each request
  typedef logic [31:0] data_t;

  // Downstream credit count, wide enough for up to 15 credits per port
  typedef logic [3:0] credit_t;

  // The holding stage is either free or carries exactly one request
  typedef enum logic [0:0] {
    route_empty,
    route_held
  } route_state_t;

endpackage

`default_nettype wire

// ==== source/addr_decode_dync.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_decode_dync #(
  parameter int unsigned NoIndices = 4,
  parameter int unsigned NoRules   = 4,
  parameter bit          Napot     = 1'b0,
  localparam int unsigned IdxWidth = addr_map_pkg::idx_width(NoIndices)
) (
  input  addr_map_pkg::addr_t                addr_i,
  input  addr_map_pkg::addr_t [NoRules-1:0]  rule_start_i,
  input  addr_map_pkg::addr_t [NoRules-1:0]  rule_end_i,
  input  logic [NoRules-1:0][IdxWidth-1:0]   rule_idx_i,
  input  logic                               en_default_idx_i,
  input  logic [IdxWidth-1:0]                default_idx_i,
  input  logic                               config_ongoing_i,
  output logic [IdxWidth-1:0]                idx_o,
  output logic                               dec_valid_o,
  output logic                               dec_error_o
);

  // One hit bit per rule, evaluated independently of priority
  logic [NoRules-1:0] rule_hit;

  always_comb begin
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (Napot) begin
        // Base and mask form, the end field holds the mask
        rule_hit[i] = ((rule_start_i[i] & rule_end_i[i]) == (addr_i & rule_end_i[i]));
      end else begin
        // Start is inclusive, end is exclusive, and an end of zero runs to the top
        rule_hit[i] = (addr_i >= rule_start_i[i]) &&
                      ((addr_i < rule_end_i[i]) || (rule_end_i[i] == '0));
      end
    end
  end

  always_comb begin
    // Unmatched addresses fall to the default port when it is enabled
    // The default route counts as a valid decode so the router can forward it
    dec_valid_o = en_default_idx_i & ~config_ongoing_i;
    // An open configuration window hides errors as well as hits
    dec_error_o = ~en_default_idx_i & ~config_ongoing_i;
    idx_o       = en_default_idx_i ? default_idx_i : '0;

    // Walk the rules upwards so the highest matching slot is the last to write
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (rule_hit[i]) begin
        dec_valid_o = ~config_ongoing_i;
        dec_error_o = 1'b0;
        // During configuration the index is parked on the default
        idx_o       = config_ongoing_i ? default_idx_i : rule_idx_i[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/addr_map_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_map_regs #(
  parameter int unsigned NoPorts = 4,
  parameter int unsigned NoRules = 4,
  localparam int unsigned IdxWidth = addr_map_pkg::idx_width(NoPorts)
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cfg_begin_i,
  input  logic                               cfg_commit_i,
  input  logic                               cfg_we_i,
  input  addr_map_pkg::rule_sel_t            cfg_sel_i,
  input  addr_map_pkg::addr_t                cfg_start_i,
  input  addr_map_pkg::addr_t                cfg_end_i,
  input  logic [IdxWidth-1:0]                cfg_idx_i,
  input  logic                               cfg_default_we_i,
  input  logic                               cfg_default_en_i,
  input  logic [IdxWidth-1:0]                cfg_default_idx_i,
  output addr_map_pkg::addr_t [NoRules-1:0]  rule_start_o,
  output addr_map_pkg::addr_t [NoRules-1:0]  rule_end_o,
  output logic [NoRules-1:0][IdxWidth-1:0]   rule_idx_o,
  output logic                               default_en_o,
  output logic [IdxWidth-1:0]                default_idx_o,
  output logic                               config_ongoing_o
);

  // Window flag, high while software is rewriting the map
  logic config_q;

  // Rule slots and the default route
  addr_map_pkg::addr_t [NoRules-1:0] start_q;
  addr_map_pkg::addr_t [NoRules-1:0] end_q;
  logic [NoRules-1:0][IdxWidth-1:0]  idx_q;
  logic                              default_en_q;
  logic [IdxWidth-1:0]               default_idx_q;

  // The window opens one cycle after begin and stays open through the commit cycle
  // A commit wins if both strobes arrive together
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      config_q <= 1'b0;
    end else if (cfg_commit_i) begin
      config_q <= 1'b0;
    end else if (cfg_begin_i) begin
      config_q <= 1'b1;
    end
  end

  // Rule writes only land while the window is open
  // Slot numbers beyond NoRules match nothing and are dropped
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q <= '0;
      end_q   <= '0;
      idx_q   <= '0;
    end else if (config_q && cfg_we_i) begin
      for (int unsigned i = 0; i < NoRules; i++) begin
        if (cfg_sel_i == addr_map_pkg::rule_sel_t'(i)) begin
          start_q[i] <= cfg_start_i;
          end_q[i]   <= cfg_end_i;
          idx_q[i]   <= cfg_idx_i;
        end
      end
    end
  end

  // Default route, disabled after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      default_en_q  <= 1'b0;
      default_idx_q <= '0;
    end else if (config_q && cfg_default_we_i) begin
      default_en_q  <= cfg_default_en_i;
      default_idx_q <= cfg_default_idx_i;
    end
  end

  assign rule_start_o     = start_q;
  assign rule_end_o       = end_q;
  assign rule_idx_o       = idx_q;
  assign default_en_o     = default_en_q;
  assign default_idx_o    = default_idx_q;
  assign config_ongoing_o = config_q;

endmodule

`default_nettype wire

// ==== source/credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
  parameter int unsigned MaxCredits = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic send_i,
  input  logic credit_i,
  output logic has_credit_o
);

  // Credits the downstream port still grants us
  router_pkg::credit_t count_q;

  // A send spends one credit and a returned pulse restores one
  // Both in the same cycle cancel out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= router_pkg::credit_t'(MaxCredits);
    end else begin
      unique case ({send_i, credit_i})
        2'b10: begin
          count_q <= count_q - router_pkg::credit_t'(1);
        end
        2'b01: begin
          count_q <= count_q + router_pkg::credit_t'(1);
        end
        default: begin
          count_q <= count_q;
        end
      endcase
    end
  end

  // Sending is allowed as long as one credit is left
  assign has_credit_o = (count_q != '0);

endmodule

`default_nettype wire

// ==== source/req_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_router #(
  parameter int unsigned NoPorts = 4,
  localparam int unsigned IdxWidth = addr_map_pkg::idx_width(NoPorts)
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_valid_i,
  input  addr_map_pkg::addr_t   in_addr_i,
  input  router_pkg::data_t     in_data_i,
  input  logic [IdxWidth-1:0]   dec_idx_i,
  input  logic                  dec_valid_i,
  input  logic                  dec_error_i,
  input  logic [NoPorts-1:0]    has_credit_i,
  output addr_map_pkg::addr_t   held_addr_o,
  output logic [NoPorts-1:0]    out_valid_o,
  output addr_map_pkg::addr_t   out_addr_o,
  output router_pkg::data_t     out_data_o,
  output logic                  err_valid_o,
  output addr_map_pkg::addr_t   err_addr_o,
  output logic                  in_credit_o
);

  router_pkg::route_state_t state_q;
  router_pkg::route_state_t state_d;

  // Payload of the held request
  addr_map_pkg::addr_t addr_q;
  router_pkg::data_t   data_q;

  logic held;
  logic fwd;
  logic drop;
  logic leave;
  logic accept;

  assign held = (state_q == router_pkg::route_held);

  // Only the decoded port fires, and only while it still has credit
  // With no credit the request simply waits in the stage
  always_comb begin
    out_valid_o = '0;
    for (int unsigned k = 0; k < NoPorts; k++) begin
      if (held && dec_valid_i && (dec_idx_i == IdxWidth'(k))) begin
        out_valid_o[k] = has_credit_i[k];
      end
    end
  end

  assign fwd  = |out_valid_o;
  // The decoder already masks errors while the map is being rewritten
  assign drop = held & dec_error_i;

  // Either outcome frees the entry and hands the upstream credit back
  assign leave = fwd | drop;

  // A new request may land in the same cycle the old one departs
  assign accept = in_valid_i & (~held | leave);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      router_pkg::route_empty: begin
        if (in_valid_i) begin
          state_d = router_pkg::route_held;
        end
      end
      router_pkg::route_held: begin
        if (leave && !in_valid_i) begin
          state_d = router_pkg::route_empty;
        end
      end
      default: begin
        state_d = router_pkg::route_empty;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= router_pkg::route_empty;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload registers follow the accept strobe
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= in_addr_i;
      data_q <= in_data_i;
    end
  end

  // The decoder sees the held address, so routing starts in the cycle after sampling
  assign held_addr_o = addr_q;
  assign out_addr_o  = addr_q;
  assign out_data_o  = data_q;
  assign err_valid_o = drop;
  assign err_addr_o  = addr_q;
  assign in_credit_o = leave;

endmodule

`default_nettype wire

// ==== source/addr_router_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_router_top #(
  parameter int unsigned NoPorts    = 4,
  parameter int unsigned NoRules    = 4,
  parameter int unsigned MaxCredits = 2,
  localparam int unsigned IdxWidth  = addr_map_pkg::idx_width(NoPorts)
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Upstream request port
  input  logic                    in_valid_i,
  input  addr_map_pkg::addr_t     in_addr_i,
  input  router_pkg::data_t       in_data_i,
  output logic                    in_credit_o,
  // Downstream ports, address and data are shared
  output logic [NoPorts-1:0]      out_valid_o,
  output addr_map_pkg::addr_t     out_addr_o,
  output router_pkg::data_t       out_data_o,
  input  logic [NoPorts-1:0]      out_credit_i,
  // Dropped requests
  output logic                    err_valid_o,
  output addr_map_pkg::addr_t     err_addr_o,
  // Map configuration
  input  logic                    cfg_begin_i,
  input  logic                    cfg_commit_i,
  input  logic                    cfg_we_i,
  input  addr_map_pkg::rule_sel_t cfg_sel_i,
  input  addr_map_pkg::addr_t     cfg_start_i,
  input  addr_map_pkg::addr_t     cfg_end_i,
  input  logic [IdxWidth-1:0]     cfg_idx_i,
  input  logic                    cfg_default_we_i,
  input  logic                    cfg_default_en_i,
  input  logic [IdxWidth-1:0]     cfg_default_idx_i
);

  // Only plain ranges are used in this router
  localparam bit Napot = 1'b0;

  addr_map_pkg::addr_t [NoRules-1:0] rule_start;
  addr_map_pkg::addr_t [NoRules-1:0] rule_end;
  logic [NoRules-1:0][IdxWidth-1:0]  rule_idx;
  logic                              default_en;
  logic [IdxWidth-1:0]               default_idx;
  logic                              config_ongoing;

  addr_map_pkg::addr_t               held_addr;
  logic [IdxWidth-1:0]               dec_idx;
  logic                              dec_valid;
  logic                              dec_error;
  logic [NoPorts-1:0]                has_credit;
  logic [NoPorts-1:0]                send;

  addr_map_regs #(
    .NoPorts (NoPorts),
    .NoRules (NoRules)
  ) u_map_regs (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .cfg_begin_i       (cfg_begin_i),
    .cfg_commit_i      (cfg_commit_i),
    .cfg_we_i          (cfg_we_i),
    .cfg_sel_i         (cfg_sel_i),
    .cfg_start_i       (cfg_start_i),
    .cfg_end_i         (cfg_end_i),
    .cfg_idx_i         (cfg_idx_i),
    .cfg_default_we_i  (cfg_default_we_i),
    .cfg_default_en_i  (cfg_default_en_i),
    .cfg_default_idx_i (cfg_default_idx_i),
    .rule_start_o      (rule_start),
    .rule_end_o        (rule_end),
    .rule_idx_o        (rule_idx),
    .default_en_o      (default_en),
    .default_idx_o     (default_idx),
    .config_ongoing_o  (config_ongoing)
  );

  addr_decode_dync #(
    .NoIndices (NoPorts),
    .NoRules   (NoRules),
    .Napot     (Napot)
  ) u_decode (
    .addr_i           (held_addr),
    .rule_start_i     (rule_start),
    .rule_end_i       (rule_end),
    .rule_idx_i       (rule_idx),
    .en_default_idx_i (default_en),
    .default_idx_i    (default_idx),
    .config_ongoing_i (config_ongoing),
    .idx_o            (dec_idx),
    .dec_valid_o      (dec_valid),
    .dec_error_o      (dec_error)
  );

  req_router #(
    .NoPorts (NoPorts)
  ) u_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_addr_i    (in_addr_i),
    .in_data_i    (in_data_i),
    .dec_idx_i    (dec_idx),
    .dec_valid_i  (dec_valid),
    .dec_error_i  (dec_error),
    .has_credit_i (has_credit),
    .held_addr_o  (held_addr),
    .out_valid_o  (send),
    .out_addr_o   (out_addr_o),
    .out_data_o   (out_data_o),
    .err_valid_o  (err_valid_o),
    .err_addr_o   (err_addr_o),
    .in_credit_o  (in_credit_o)
  );

  // One credit account per downstream port, charged by that port's valid bit
  for (genvar k = 0; k < NoPorts; k++) begin : g_credit
    credit_counter #(
      .MaxCredits (MaxCredits)
    ) u_credit (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .send_i       (send[k]),
      .credit_i     (out_credit_i[k]),
      .has_credit_o (has_credit[k])
    );
  end

  assign out_valid_o = send;

endmodule

`default_nettype wire

// ==== tests/tb_addr_router_model.svh ====
`ifndef TB_ADDR_ROUTER_MODEL_SVH
`define TB_ADDR_ROUTER_MODEL_SVH

  // Galois LFSR stepped once per random bit taken
  function automatic logic next_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Expected port for an address or -1 when the request must be dropped
  // Later slots overwrite earlier hits, so the highest slot wins
  function automatic int ref_port(input logic [31:0] a);
    int p;
    p = m_def_en ? m_def_idx : -1;
    for (int i = 0; i < NUM_RULES; i++) begin
      if ((a >= m_start[i]) && ((a < m_end[i]) || (m_end[i] == 32'h0))) begin
        p = m_idx[i];
      end
    end
    return p;
  endfunction

  function automatic logic [NUM_PORTS-1:0] port_mask(input logic [31:0] a);
    int p;
    p = ref_port(a);
    return (p < 0) ? '0 : (NUM_PORTS'(1) << p);
  endfunction

  // True when the request may legally wait for lack of downstream credit
  function automatic logic port_blocked(input logic [31:0] a);
    int p;
    p = ref_port(a);
    return (p >= 0) && (outstanding[p] >= MAX_CREDITS);
  endfunction

  a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(out_valid_o))
    else begin
      $display("[ERROR] %0t: more than one out_valid_o bit set", $time);
      error_count++;
    end

  a_route: assert property (@(posedge clk) disable iff (!rst_n)
    (|out_valid_o) |-> (out_valid_o == port_mask(out_addr_o)) &&
    (out_addr_o == exp_addr) && (out_data_o == exp_data))
    else begin
      $display("[ERROR] %0t: wrong port or payload for %h", $time, out_addr_o);
      error_count++;
    end

  a_drop: assert property (@(posedge clk) disable iff (!rst_n)
    err_valid_o |-> (ref_port(err_addr_o) < 0) && (err_addr_o == exp_addr) && !(|out_valid_o))
    else begin
      $display("[ERROR] %0t: unexpected drop of %h", $time, err_addr_o);
      error_count++;
    end

  a_blank: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_open_m |-> !(|out_valid_o) && !err_valid_o)
    else begin
      $display("[ERROR] %0t: output while the window is open", $time);
      error_count++;
    end

  a_credit_out: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit_o |-> ((|out_valid_o) || err_valid_o))
    else begin
      $display("[ERROR] %0t: in_credit_o without a send or drop", $time);
      error_count++;
    end

  a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
    ((|out_valid_o) || err_valid_o) |-> in_credit_o)
    else begin
      $display("[ERROR] %0t: send or drop without in_credit_o", $time);
      error_count++;
    end

  // A request sampled at edge n must leave before edge n+1 unless it is allowed to wait
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i |=> ((|out_valid_o) || err_valid_o || cfg_open_m || port_blocked(exp_addr)))
    else begin
      $display("[ERROR] %0t: request %h missed one-cycle latency", $time, exp_addr);
      error_count++;
    end

  for (genvar k = 0; k < NUM_PORTS; k++) begin : g_outstanding
    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding[k] <= MAX_CREDITS)
      else begin
        $display("[ERROR] %0t: port %0d over its credit limit", $time, k);
        error_count++;
      end
  end

`endif

// ==== tests/tb_addr_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_addr_router;

  localparam int NUM_PORTS      = 4;
  localparam int NUM_RULES      = 4;
  localparam int MAX_CREDITS    = 2;
  localparam int TOTAL_REQS     = 46;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20 + 400;

  logic clk;
  logic rst_n;
  logic in_valid_i;
  logic [31:0] in_addr_i;
  logic [31:0] in_data_i;
  logic in_credit_o;
  logic [NUM_PORTS-1:0] out_valid_o;
  logic [31:0] out_addr_o;
  logic [31:0] out_data_o;
  logic [NUM_PORTS-1:0] out_credit_i;
  logic err_valid_o;
  logic [31:0] err_addr_o;
  logic cfg_begin_i;
  logic cfg_commit_i;
  logic cfg_we_i;
  logic [2:0] cfg_sel_i;
  logic [31:0] cfg_start_i;
  logic [31:0] cfg_end_i;
  logic [1:0] cfg_idx_i;
  logic cfg_default_we_i;
  logic cfg_default_en_i;
  logic [1:0] cfg_default_idx_i;

  // Map as the testbench wrote it together with the window and credit bookkeeping
  logic [31:0] m_start[NUM_RULES];
  logic [31:0] m_end[NUM_RULES];
  int m_idx[NUM_RULES];
  logic m_def_en;
  int m_def_idx;
  logic cfg_open_m;
  int outstanding[NUM_PORTS];
  int unsigned due_q[NUM_PORTS][$];
  logic [31:0] lfsr_q = 32'hbc0b;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  logic up_credit;
  logic hold_credits;
  int unsigned cycle_cnt;
  int error_count;
  int accepted_cnt;
  int credit_cnt;
  int tests_done;

  addr_router_top #(
    .NoPorts    (NUM_PORTS),
    .NoRules    (NUM_RULES),
    .MaxCredits (MAX_CREDITS)
  ) dut0 (
    .clk_i (clk), .rst_n_i (rst_n),
    .in_valid_i (in_valid_i), .in_addr_i (in_addr_i), .in_data_i (in_data_i),
    .in_credit_o (in_credit_o),
    .out_valid_o (out_valid_o), .out_addr_o (out_addr_o), .out_data_o (out_data_o),
    .out_credit_i (out_credit_i),
    .err_valid_o (err_valid_o), .err_addr_o (err_addr_o),
    .cfg_begin_i (cfg_begin_i), .cfg_commit_i (cfg_commit_i), .cfg_we_i (cfg_we_i),
    .cfg_sel_i (cfg_sel_i), .cfg_start_i (cfg_start_i), .cfg_end_i (cfg_end_i),
    .cfg_idx_i (cfg_idx_i), .cfg_default_we_i (cfg_default_we_i),
    .cfg_default_en_i (cfg_default_en_i), .cfg_default_idx_i (cfg_default_idx_i)
  );

  `include "tb_addr_router_model.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // The window mirror follows the same begin and commit strobes as the map registers
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_open_m <= 1'b0;
      cycle_cnt  <= 0;
    end else begin
      cfg_open_m <= cfg_commit_i ? 1'b0 : (cfg_begin_i ? 1'b1 : cfg_open_m);
      cycle_cnt  <= cycle_cnt + 1;
    end
  end

  // Requests in flight per port counted as forwarded minus credits returned
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_PORTS; k++) outstanding[k] <= 0;
    end else begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        outstanding[k] <= outstanding[k] + int'(out_valid_o[k]) - int'(out_credit_i[k]);
      end
    end
  end

  // Sinks record each delivery mid-cycle and pick a return delay from the LFSR
  always @(negedge clk) begin
    if (rst_n) begin
      for (int k = 0; k < NUM_PORTS; k++) begin
        if (out_valid_o[k]) due_q[k].push_back(cycle_cnt + 1 + rand_bits(3));
      end
      if (in_credit_o) begin
        up_credit = 1'b1;
        credit_cnt++;
      end
    end
  end

  // At most one credit pulse per port per cycle
  always @(posedge clk) begin
    #2;
    for (int k = 0; k < NUM_PORTS; k++) begin
      out_credit_i[k] = 1'b0;
      if (!hold_credits && (due_q[k].size() > 0) && (due_q[k][0] <= cycle_cnt)) begin
        out_credit_i[k] = 1'b1;
        void'(due_q[k].pop_front());
      end
    end
  end

  task automatic send_req(input logic [31:0] addr, input logic [31:0] data);
    wait (up_credit);
    @(posedge clk);
    #2;
    in_valid_i = 1'b1;
    in_addr_i  = addr;
    in_data_i  = data;
    exp_addr   = addr;
    exp_data   = data;
    up_credit  = 1'b0;
    accepted_cnt++;
    @(posedge clk);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic pulse_cfg(input logic commit);
    @(posedge clk);
    #2;
    cfg_begin_i  = !commit;
    cfg_commit_i = commit;
    @(posedge clk);
    #2;
    cfg_begin_i  = 1'b0;
    cfg_commit_i = 1'b0;
  endtask

  task automatic write_rule(input int sel, input logic [31:0] s, input logic [31:0] e,
                            input int idx);
    @(posedge clk);
    #2;
    cfg_we_i = 1'b1;
    cfg_sel_i = 3'(sel);
    cfg_start_i = s;
    cfg_end_i = e;
    cfg_idx_i = 2'(idx);
    m_start[sel] = s;
    m_end[sel] = e;
    m_idx[sel] = idx;
    @(posedge clk);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic write_default(input logic en, input int idx);
    @(posedge clk);
    #2;
    cfg_default_we_i = 1'b1;
    cfg_default_en_i = en;
    cfg_default_idx_i = 2'(idx);
    m_def_en = en;
    m_def_idx = idx;
    @(posedge clk);
    #2;
    cfg_default_we_i = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_done++;
    wait (up_credit);
    $display("test %0d %s: %s", tests_done, name,
             (error_count == errs_before) ? "ok" : "errors seen");
  endtask

  initial begin
    int errs;
    logic [31:0] bases[4];
    bases = '{32'h0100_0000, 32'h0A00_0000, 32'h1C00_0000, 32'h3000_0000};
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    in_addr_i = '0;
    in_data_i = '0;
    out_credit_i = '0;
    cfg_begin_i = 1'b0;
    cfg_commit_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_sel_i = '0;
    cfg_start_i = '0;
    cfg_end_i = '0;
    cfg_idx_i = '0;
    cfg_default_we_i = 1'b0;
    cfg_default_en_i = 1'b0;
    cfg_default_idx_i = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      m_start[i] = '0;
      m_end[i] = '0;
      m_idx[i] = 0;
    end
    m_def_en = 1'b0;
    m_def_idx = 0;
    up_credit = 1'b1;
    hold_credits = 1'b0;
    error_count = 0;
    accepted_cnt = 0;
    credit_cnt = 0;
    tests_done = 0;
    exp_addr = '0;
    exp_data = '0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Overlapping ranges where slot 2 runs to the top and slot 3 sits inside it
    errs = error_count;
    pulse_cfg(1'b0);
    write_rule(0, 32'h0100_0000, 32'h1000_0000, 0);
    write_rule(1, 32'h0800_0000, 32'h2000_0000, 1);
    write_rule(2, 32'h1800_0000, 32'h0000_0000, 2);
    write_rule(3, 32'h3000_0000, 32'h3100_0000, 3);
    pulse_cfg(1'b1);
    send_req(32'h0C00_0000, 32'h1234_5678);
    for (int n = 0; n < 38; n++) begin
      send_req(bases[rand_bits(2)] + rand_bits(20), rand_bits(32));
    end
    send_req(rand_bits(32), rand_bits(32));
    finish_test("range routing with priority", errs);

    // Unmatched address is first dropped and then caught by the default port
    errs = error_count;
    send_req(32'h0000_1000, 32'hdead_0001);
    pulse_cfg(1'b0);
    write_default(1'b1, 3);
    pulse_cfg(1'b1);
    send_req(32'h0000_1000, 32'hdead_0002);
    finish_test("default and error", errs);

    // A request held across the window follows the rewritten slot
    errs = error_count;
    pulse_cfg(1'b0);
    send_req(32'h3000_0100, 32'hc0f1_9000);
    write_rule(3, 32'h3000_0000, 32'h3100_0000, 0);
    repeat (4) @(posedge clk);
    pulse_cfg(1'b1);
    finish_test("configuration window", errs);

    // Withheld credits stall the third request until the sink releases them
    errs = error_count;
    while ((outstanding[1] != 0) || (due_q[1].size() != 0)) begin
      @(posedge clk);
    end
    hold_credits = 1'b1;
    for (int n = 0; n < 3; n++) send_req(32'h0A00_0040 + n, rand_bits(32));
    repeat (10) @(posedge clk);
    hold_credits = 1'b0;
    finish_test("downstream back-pressure", errs);

    // Every accepted request must return exactly one upstream credit
    errs = error_count;
    for (int k = 0; k < NUM_PORTS; k++) wait (outstanding[k] == 0);
    assert (accepted_cnt == credit_cnt)
      else begin
        $display("[ERROR] %0t: %0d accepted, %0d credits", $time, accepted_cnt,
                 credit_cnt);
        error_count++;
      end
    finish_test("upstream credit and latency", errs);

    $display("%0d tests, %0d errors", tests_done, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 40);
    $display("The run timed out before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== addr_router.f ====
+incdir+tests
source/addr_map_pkg.sv
source/router_pkg.sv
source/addr_decode_dync.sv
source/addr_map_regs.sv
source/credit_counter.sv
source/req_router.sv
source/addr_router_top.sv
tests/tb_addr_router.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only --assert --timing
TOP       ?= tb_addr_router
FILELIST  ?= addr_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
